//--- verilog/gnn_params.svh
`ifndef GNN_PARAMS_SVH
`define GNN_PARAMS_SVH

// slots per batch in each reservation station
`define NUM_PE 4

// feature fragments
`define FRAG_W 2
`define MAX_FRAGS 8
`define FV_W (`FRAG_W * `MAX_FRAGS)

// node identifiers and counts
`define NODE_ID_W 8
`define NCOUNT_W 5

// shared feature memory
`define WORD_W 16
`define MEM_DEPTH 64
`define ADDR_W 6

// streamer / station pairs
`define NUM_LANES 2

`endif

//--- verilog/gnn_pkg.sv
`include "gnn_params.svh"

package gnn_pkg;

    // header word of a node record
    typedef struct packed {
        logic [`WORD_W-`NODE_ID_W-3-1:0] spare;
        // fragment count minus one
        logic [2:0]                      last_frag;
        logic [`NODE_ID_W-1:0]           node_id;
    } node_hdr_t;

    // data word, one fragment in the low bits
    typedef struct packed {
        logic [`WORD_W-`FRAG_W-1:0] spare;
        logic [`FRAG_W-1:0]         frag;
    } node_data_t;

    // one memory word, read as header or data depending on record position
    typedef union packed {
        node_hdr_t  hdr;
        node_data_t data;
    } mem_word_u;

endpackage

//--- verilog/feature_store.sv
`timescale 1ns/10ps

`include "gnn_params.svh"

module feature_store
    import gnn_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 load_en,
    input  logic [`ADDR_W-1:0]                   load_addr,
    input  mem_word_u                            load_data,
    input  logic [`NUM_LANES-1:0]                rd_req,
    input  logic [`NUM_LANES-1:0][`ADDR_W-1:0]   rd_addr,
    output logic [`NUM_LANES-1:0]                rd_gnt,
    output mem_word_u                            rd_data
);

    localparam int LANE_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;

    mem_word_u mem [`MEM_DEPTH];

    // lane that got the most recent grant
    logic [LANE_W-1:0] last_lane;
    logic [LANE_W-1:0] gnt_lane;
    logic              gnt_any;

    // round-robin search starting after last winner
    always_comb begin
        int idx;
        rd_gnt   = '0;
        gnt_lane = last_lane;
        gnt_any  = 1'b0;
        for (int i = 1; i <= `NUM_LANES; i++) begin
            idx = (int'(last_lane) + i) % `NUM_LANES;
            if (!gnt_any && rd_req[idx]) begin
                gnt_any  = 1'b1;
                gnt_lane = LANE_W'(idx);
            end
        end
        if (gnt_any) begin
            rd_gnt[gnt_lane] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // lane 0 wins the first tie
            last_lane <= LANE_W'(`NUM_LANES - 1);
        end else if (gnt_any) begin
            last_lane <= gnt_lane;
        end
    end

    // load port, written at the edge it arrives
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // read word comes back the cycle after the grant
    always_ff @(posedge clk) begin
        if (gnt_any) begin
            rd_data <= mem[rd_addr[gnt_lane]];
        end
    end

endmodule

//--- verilog/bank_streamer.sv
`timescale 1ns/10ps

`include "gnn_params.svh"

module bank_streamer
    import gnn_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [`ADDR_W-1:0]    base_addr,
    input  logic [`NCOUNT_W-1:0]  node_count,
    output logic                  rd_req,
    output logic [`ADDR_W-1:0]    rd_addr,
    input  logic                  rd_gnt,
    input  mem_word_u             rd_data,
    output logic                  sos,
    output logic                  eos,
    output logic [`NODE_ID_W-1:0] node_id,
    output logic [`FRAG_W-1:0]    frag,
    output logic                  done
);

    localparam int IDX_W = $clog2(`MAX_FRAGS);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_HDR  = 3'd1;
    localparam logic [2:0] S_DATA = 3'd2;
    localparam logic [2:0] S_EMIT = 3'd3;
    localparam logic [2:0] S_NEXT = 3'd4;

    logic [2:0]           state;
    logic [`NCOUNT_W-1:0] nodes_left;
    logic [IDX_W-1:0]     last_frag;
    logic [IDX_W:0]       req_idx;
    logic [IDX_W-1:0]     wr_idx;
    logic [IDX_W-1:0]     emit_idx;
    // rd_data holds our word this cycle
    logic                 pend;
    logic [`FRAG_W-1:0]   frag_buf [`MAX_FRAGS];

    // header needs a single request, data one per fragment
    assign rd_req = ((state == S_HDR) && !pend) ||
                    ((state == S_DATA) && (req_idx <= {1'b0, last_frag}));

    assign sos  = (state == S_EMIT) && (emit_idx == '0);
    assign eos  = (state == S_EMIT) && (emit_idx == last_frag);
    assign frag = frag_buf[emit_idx];
    assign done = (state == S_NEXT) && (nodes_left == 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            pend       <= 1'b0;
            rd_addr    <= '0;
            nodes_left <= '0;
            req_idx    <= '0;
            wr_idx     <= '0;
            emit_idx   <= '0;
        end else begin
            pend <= rd_gnt;
            // address runs straight on into the next record
            if (rd_gnt) begin
                rd_addr <= rd_addr + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        rd_addr    <= base_addr;
                        nodes_left <= node_count;
                        state      <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (pend) begin
                        req_idx <= '0;
                        wr_idx  <= '0;
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rd_gnt) begin
                        req_idx <= req_idx + 1'b1;
                    end
                    if (pend) begin
                        wr_idx <= wr_idx + 1'b1;
                        if (wr_idx == last_frag) begin
                            emit_idx <= '0;
                            state    <= S_EMIT;
                        end
                    end
                end
                S_EMIT: begin
                    if (eos) begin
                        state <= S_NEXT;
                    end else begin
                        emit_idx <= emit_idx + 1'b1;
                    end
                end
                S_NEXT: begin
                    nodes_left <= nodes_left - 1'b1;
                    emit_idx   <= '0;
                    state      <= (nodes_left == 1) ? S_IDLE : S_HDR;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if ((state == S_HDR) && pend) begin
            node_id   <= rd_data.hdr.node_id;
            last_frag <= rd_data.hdr.last_frag;
        end
        if ((state == S_DATA) && pend) begin
            frag_buf[wr_idx] <= rd_data.data.frag;
        end
    end

endmodule

//--- verilog/vertex_rs.sv
`timescale 1ns/10ps

`include "gnn_params.svh"

module vertex_rs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sos,
    input  logic                                eos,
    input  logic [`NODE_ID_W-1:0]               node_id,
    input  logic [`FRAG_W-1:0]                  frag,
    output logic                                valid,
    output logic [`NUM_PE-1:0][`FV_W-1:0]       fv_data,
    output logic [`NUM_PE-1:0][`NODE_ID_W-1:0]  slot_node_id
);

    localparam int SLOT_W = (`NUM_PE > 1) ? $clog2(`NUM_PE) : 1;
    localparam int IDX_W  = $clog2(`MAX_FRAGS);
    localparam int BIT_W  = $clog2(`FV_W);

    logic [`NUM_PE-1:0][`FV_W-1:0] slot_fv;
    logic [IDX_W-1:0]              count;
    logic                          counting;
    logic [SLOT_W-1:0]             slot_idx;
    logic                          eos_last;
    logic                          eos_rise;
    logic [BIT_W-1:0]              boundary;

    assign boundary = BIT_W'(count * `FRAG_W);
    assign eos_rise = eos && !eos_last;

    // fragment position within the current node
    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            counting <= 1'b0;
        end else begin
            if (sos) begin
                counting <= 1'b1;
                count    <= count + 1'b1;
            end
            if (counting) begin
                if ((count == IDX_W'(`MAX_FRAGS - 1)) || eos) begin
                    count    <= '0;
                    counting <= 1'b0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // slot pointer moves on each new eos
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_idx <= '0;
            eos_last <= 1'b0;
        end else begin
            eos_last <= eos;
            if (eos_rise) begin
                slot_idx <= (slot_idx == SLOT_W'(`NUM_PE - 1)) ? '0 : slot_idx + 1'b1;
            end
        end
    end

    // untouched upper bits keep the older node's fragments
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_fv      <= '0;
            slot_node_id <= '0;
        end else if (sos || counting) begin
            slot_fv[slot_idx][boundary +: `FRAG_W] <= frag;
            slot_node_id[slot_idx]                 <= node_id;
        end
    end

    // batch complete when the last slot sees its eos
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= eos_rise && (slot_idx == SLOT_W'(`NUM_PE - 1));
        end
    end

    assign fv_data = valid ? slot_fv : '0;

endmodule

//--- verilog/vertex_stage.sv
`timescale 1ns/10ps

`include "gnn_params.svh"

module vertex_stage
    import gnn_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               load_en,
    input  logic [`ADDR_W-1:0]                                 load_addr,
    input  mem_word_u                                          load_data,
    input  logic [`NUM_LANES-1:0]                              start,
    input  logic [`NUM_LANES-1:0][`ADDR_W-1:0]                 base_addr,
    input  logic [`NUM_LANES-1:0][`NCOUNT_W-1:0]               node_count,
    output logic [`NUM_LANES-1:0]                              done,
    output logic [`NUM_LANES-1:0]                              valid,
    output logic [`NUM_LANES-1:0][`NUM_PE-1:0][`FV_W-1:0]      fv_data,
    output logic [`NUM_LANES-1:0][`NUM_PE-1:0][`NODE_ID_W-1:0] slot_node_id
);

    logic [`NUM_LANES-1:0]                  rd_req;
    logic [`NUM_LANES-1:0][`ADDR_W-1:0]     rd_addr;
    logic [`NUM_LANES-1:0]                  rd_gnt;
    mem_word_u                              rd_data;
    logic [`NUM_LANES-1:0]                  sos;
    logic [`NUM_LANES-1:0]                  eos;
    logic [`NUM_LANES-1:0][`NODE_ID_W-1:0]  node_id;
    logic [`NUM_LANES-1:0][`FRAG_W-1:0]     frag;

    feature_store store_i (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_gnt    (rd_gnt),
        .rd_data   (rd_data)
    );

    // one streamer and one station per lane, sharing the read bus
    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        bank_streamer streamer_i (
            .clk        (clk),
            .reset      (reset),
            .start      (start[l]),
            .base_addr  (base_addr[l]),
            .node_count (node_count[l]),
            .rd_req     (rd_req[l]),
            .rd_addr    (rd_addr[l]),
            .rd_gnt     (rd_gnt[l]),
            .rd_data    (rd_data),
            .sos        (sos[l]),
            .eos        (eos[l]),
            .node_id    (node_id[l]),
            .frag       (frag[l]),
            .done       (done[l])
        );

        vertex_rs rs_i (
            .clk          (clk),
            .reset        (reset),
            .sos          (sos[l]),
            .eos          (eos[l]),
            .node_id      (node_id[l]),
            .frag         (frag[l]),
            .valid        (valid[l]),
            .fv_data      (fv_data[l]),
            .slot_node_id (slot_node_id[l])
        );
    end

endmodule

//--- bench/vertex_stage_assert.sv
`timescale 1ns/10ps

`include "gnn_params.svh"

module vertex_stage_assert (
    input logic                                          clk,
    input logic                                          reset,
    input logic [`NUM_LANES-1:0]                         rd_gnt,
    input logic [`NUM_LANES-1:0]                         valid,
    input logic [`NUM_LANES-1:0][`NUM_PE-1:0][`FV_W-1:0] fv_data
);

    // failed assertions so far
    int failures = 0;

    // one grant per cycle at most
    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(rd_gnt))
        else begin
            $error("more than one read grant in a cycle");
            failures++;
        end

    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        valid_pulse: assert property (@(posedge clk) disable iff (reset) valid[l] |=> !valid[l])
            else begin
                $error("lane %0d valid high for two cycles", l);
                failures++;
            end

        // feature words only visible with valid
        fv_gated: assert property (@(posedge clk) disable iff (reset)
                                   !valid[l] |-> (fv_data[l] == '0))
            else begin
                $error("lane %0d fv_data nonzero while valid low", l);
                failures++;
            end
    end

endmodule

//--- bench/vertex_stage_tb.sv
`timescale 1ns/10ps

`include "gnn_params.svh"

module vertex_stage_tb
    import gnn_pkg::*;
();

    localparam int NUM_NODES = 12;
    localparam int NUM_ROWS  = 5;

    typedef logic [`NUM_PE-1:0][`FV_W-1:0]      batch_fv_t;
    typedef logic [`NUM_PE-1:0][`NODE_ID_W-1:0] batch_id_t;

    logic                                               clk;
    logic                                               reset;
    logic                                               load_en;
    logic [`ADDR_W-1:0]                                 load_addr;
    mem_word_u                                          load_data;
    logic [`NUM_LANES-1:0]                              start;
    logic [`NUM_LANES-1:0][`ADDR_W-1:0]                 base_addr;
    logic [`NUM_LANES-1:0][`NCOUNT_W-1:0]               node_count;
    logic [`NUM_LANES-1:0]                              done;
    logic [`NUM_LANES-1:0]                              valid;
    logic [`NUM_LANES-1:0][`NUM_PE-1:0][`FV_W-1:0]      fv_data;
    logic [`NUM_LANES-1:0][`NUM_PE-1:0][`NODE_ID_W-1:0] slot_node_id;

    // fragment count per node record, long nodes first
    int                    node_frags [NUM_NODES] = '{8, 7, 8, 6, 2, 3, 2, 2, 3, 2, 2, 3};
    logic [`NODE_ID_W-1:0] node_ids [NUM_NODES];
    logic [`FRAG_W-1:0]    node_data [NUM_NODES][`MAX_FRAGS];
    int                    node_addr [NUM_NODES];

    // lanes started, first node and node count for each test row
    logic [`NUM_LANES-1:0] row_start [NUM_ROWS] = '{2'b01, 2'b10, 2'b11, 2'b11, 2'b11};
    int row_first [NUM_ROWS][`NUM_LANES] = '{'{0, 0}, '{0, 8}, '{0, 8}, '{0, 4}, '{8, 0}};
    int row_count [NUM_ROWS][`NUM_LANES] = '{'{4, 0}, '{0, 4}, '{4, 4}, '{8, 4}, '{4, 8}};

    // reference slot state and predicted batches
    batch_fv_t             ref_fv [`NUM_LANES];
    batch_id_t             ref_id [`NUM_LANES];
    int                    ref_slot [`NUM_LANES];
    batch_fv_t             exp_fv [`NUM_LANES][4];
    batch_id_t             exp_id [`NUM_LANES][4];
    int                    exp_cnt [`NUM_LANES];
    int                    got_cnt [`NUM_LANES];
    logic [`NUM_LANES-1:0] done_seen;
    int                    total_frags;
    logic                  tables_ready = 1'b0;

    vertex_stage dut_i (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .start        (start),
        .base_addr    (base_addr),
        .node_count   (node_count),
        .done         (done),
        .valid        (valid),
        .fv_data      (fv_data),
        .slot_node_id (slot_node_id)
    );

    bind vertex_stage vertex_stage_assert assert_i (
        .clk     (clk),
        .reset   (reset),
        .rd_gnt  (rd_gnt),
        .valid   (valid),
        .fv_data (fv_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERR %0t %s", $time, msg);
        abort_run();
    endtask

    task automatic check_batch(input int lane, input batch_fv_t got_fv, input batch_id_t got_id,
                               input batch_fv_t want_fv, input batch_id_t want_id);
        for (int s = 0; s < `NUM_PE; s++) begin
            if (got_fv[s] !== want_fv[s] || got_id[s] !== want_id[s]) begin
                report_mismatch($sformatf("lane %0d slot %0d got %h/%h, expected %h/%h",
                                          lane, s, got_id[s], got_fv[s], want_id[s], want_fv[s]));
            end
        end
    endtask

    task automatic check_zero(input int lane, input batch_fv_t got_fv);
        if (got_fv !== '0) begin
            report_mismatch($sformatf("lane %0d fv_data %h while valid low", lane, got_fv));
        end
    endtask

    task automatic check_done(input int lane, input int got, input int want);
        if (got != want) begin
            report_mismatch($sformatf("lane %0d done after %0d valid pulses, expected %0d",
                                      lane, got, want));
        end
    endtask

    task automatic check_flags(input string what, input logic [`NUM_LANES-1:0] got,
                               input logic [`NUM_LANES-1:0] want);
        if (got !== want) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, want));
        end
    endtask

    // fragment k lands at k*FRAG_W and higher bits keep their old value
    task automatic predict_run(input int lane, input int first, input int count);
        int n;
        exp_cnt[lane] = 0;
        got_cnt[lane] = 0;
        for (int i = 0; i < count; i++) begin
            n = first + i;
            for (int k = 0; k < node_frags[n]; k++) begin
                ref_fv[lane][ref_slot[lane]][k*`FRAG_W +: `FRAG_W] = node_data[n][k];
            end
            ref_id[lane][ref_slot[lane]] = node_ids[n];
            if (ref_slot[lane] == `NUM_PE - 1) begin
                exp_fv[lane][exp_cnt[lane]] = ref_fv[lane];
                exp_id[lane][exp_cnt[lane]] = ref_id[lane];
                exp_cnt[lane]++;
                ref_slot[lane] = 0;
            end else begin
                ref_slot[lane]++;
            end
        end
    endtask

    // header word then data words with random spare bits
    task automatic load_records(inout int seed);
        mem_word_u word;
        for (int n = 0; n < NUM_NODES; n++) begin
            word = `WORD_W'($random(seed));
            word.hdr.node_id   = node_ids[n];
            word.hdr.last_frag = 3'(node_frags[n] - 1);
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= `ADDR_W'(node_addr[n]);
            load_data <= word;
            for (int k = 0; k < node_frags[n]; k++) begin
                word = `WORD_W'($random(seed));
                word.data.frag = node_data[n][k];
                @(posedge clk);
                load_addr <= `ADDR_W'(node_addr[n] + 1 + k);
                load_data <= word;
            end
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // outputs sampled on the falling edge
    always @(negedge clk) begin
        if (!reset && tables_ready) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (valid[l] && got_cnt[l] >= exp_cnt[l]) begin
                    report_mismatch($sformatf("lane %0d valid with no batch pending", l));
                end else if (valid[l]) begin
                    check_batch(l, fv_data[l], slot_node_id[l],
                                exp_fv[l][got_cnt[l]], exp_id[l][got_cnt[l]]);
                    got_cnt[l]++;
                end else begin
                    check_zero(l, fv_data[l]);
                end
                if (done[l] && done_seen[l]) begin
                    report_mismatch($sformatf("lane %0d pulsed done twice", l));
                end else if (done[l]) begin
                    check_done(l, got_cnt[l], exp_cnt[l]);
                    done_seen[l] = 1'b1;
                end
            end
            if (dut_i.assert_i.failures != 0) begin
                $display("a bound assertion on the vertex stage failed");
                abort_run();
            end
        end
    end

    initial begin
        int limit;
        wait (tables_ready);
        limit = 30 * total_frags + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the lanes did not finish all test rows, the design seems to hang");
        abort_run();
    end

    initial begin
        int seed;
        int addr;
        reset      <= 1'b1;
        load_en    <= 1'b0;
        load_addr  <= '0;
        load_data  <= '0;
        start      <= '0;
        base_addr  <= '0;
        node_count <= '0;
        seed = 32'h2ad7;
        addr = 0;
        done_seen = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            node_ids[n]  = `NODE_ID_W'(8'h40 + 7 * n);
            node_addr[n] = addr;
            addr += 1 + node_frags[n];
            for (int k = 0; k < `MAX_FRAGS; k++) begin
                node_data[n][k] = `FRAG_W'($random(seed));
            end
        end
        total_frags = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                for (int i = 0; row_start[r][l] && i < row_count[r][l]; i++) begin
                    total_frags += node_frags[row_first[r][l] + i];
                end
            end
        end
        for (int l = 0; l < `NUM_LANES; l++) begin
            ref_fv[l]   = '0;
            ref_id[l]   = '0;
            ref_slot[l] = 0;
            exp_cnt[l]  = 0;
            got_cnt[l]  = 0;
        end
        tables_ready = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flags("valid after reset", valid, '0);
        check_flags("done after reset", done, '0);
        for (int l = 0; l < `NUM_LANES; l++) begin
            check_batch(l, fv_data[l], slot_node_id[l], '0, '0);
        end

        load_records(seed);

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            done_seen = '0;
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (row_start[r][l]) begin
                    predict_run(l, row_first[r][l], row_count[r][l]);
                    base_addr[l]  <= `ADDR_W'(node_addr[row_first[r][l]]);
                    node_count[l] <= `NCOUNT_W'(row_count[r][l]);
                end
            end
            start <= row_start[r];
            @(posedge clk);
            start <= '0;
            while (done_seen != row_start[r]) begin
                @(posedge clk);
            end
            // quiet cycles so a late valid still meets the monitor
            repeat (4) @(posedge clk);
        end

        @(posedge clk);
        if (dut_i.assert_i.failures != 0) begin
            $display("a bound assertion on the vertex stage failed");
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+verilog
verilog/gnn_pkg.sv
verilog/feature_store.sv
verilog/bank_streamer.sv
verilog/vertex_rs.sv
verilog/vertex_stage.sv
bench/vertex_stage_assert.sv
bench/vertex_stage_tb.sv

//--- Bender.yml
package:
  name: vertex_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/gnn_pkg.sv
      - verilog/feature_store.sv
      - verilog/bank_streamer.sv
      - verilog/vertex_rs.sv
      - verilog/vertex_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/vertex_stage_assert.sv
      - bench/vertex_stage_tb.sv
